// ==== fetch_icache.f ====
src/fetch_pkg.sv
src/fip_gen.sv
src/icache_bank.sv
src/refill_fsm.sv
src/beat_counter.sv
src/fetch_unit.sv
testbench/fetch_props.sv
testbench/fetch_checker.sv
testbench/tb_fetch_unit.sv

// ==== src/beat_counter.sv ====
`timescale 1ns/1ps

module beat_counter (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             clear_i,
    input  logic                             beat_i,
    output logic [fetch_pkg::beat_idx_w-1:0] beat_o,
    output logic                             last_o
);
    import fetch_pkg::*;

    logic [beat_idx_w-1:0] beat_q;

    always_ff @(posedge clk) begin
        if (rst_i || clear_i)
            beat_q <= '0;
        else if (beat_i)
            beat_q <= last_o ? '0 : beat_q + 1'b1;  // wrap after the final word
    end

    assign beat_o = beat_q;
    assign last_o = (beat_q == beat_idx_w'(beats_per_line - 1));

endmodule

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int line_addr_w    = 28;  // byte address bits 31:4
    localparam int line_w         = 128;
    localparam int beat_w         = 32;
    localparam int beats_per_line = 4;
    localparam int beat_idx_w     = 2;

    // per-bank geometry with bit 0 of a line address picking the bank
    localparam int bank_lines = 16;
    localparam int index_w    = 4;   // line address bits 4:1
    localparam int tag_w      = 23;  // line address bits 27:5

    ////////////////////////////////////////////////////////////
    // enums
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        redir_none,
        redir_branch,
        redir_resteer,
        redir_init      // highest priority
    } redirect_src_e;

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_fill
    } refill_state_e;

endpackage

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               init_i,
    input  logic                               resteer_i,
    input  logic                               branch_i,
    input  logic [31:0]                        init_addr_i,
    input  logic [31:0]                        resteer_addr_i,
    input  logic [31:0]                        branch_addr_i,
    input  logic                               fetch_ready_i,
    input  logic                               mem_req_ready_i,
    input  logic                               mem_rsp_valid_i,
    input  logic [fetch_pkg::beat_w-1:0]       mem_rsp_data_i,
    output logic                               fetch_valid_o,
    output logic [fetch_pkg::line_w-1:0]       line_even_o,
    output logic [fetch_pkg::line_w-1:0]       line_odd_o,
    output logic [fetch_pkg::line_addr_w-1:0]  fip_even_o,
    output logic [fetch_pkg::line_addr_w-1:0]  fip_odd_o,
    output logic                               mem_req_valid_o,
    output logic [fetch_pkg::line_addr_w-1:0]  mem_req_addr_o,
    output logic                               mem_rsp_ready_o
);
    import fetch_pkg::*;

    logic                  hit_even;
    logic                  hit_odd;
    logic                  fill_even;
    logic                  fill_odd;
    logic                  rsp_beat;
    logic                  beat_clear;
    logic [beat_idx_w-1:0] beat_idx;
    logic                  beat_last;

    fip_gen fip_gen_inst (
        .clk(clk), .rst_i(rst_i),
        .init_i(init_i), .resteer_i(resteer_i), .branch_i(branch_i),
        .init_addr_i(init_addr_i), .resteer_addr_i(resteer_addr_i),
        .branch_addr_i(branch_addr_i),
        .fetch_valid_i(fetch_valid_o), .fetch_ready_i(fetch_ready_i),
        .fip_even_o(fip_even_o), .fip_odd_o(fip_odd_o)
    );

    ////////////////////////////////////////////////////////////
    // banks share fill address and data but not the enables
    ////////////////////////////////////////////////////////////

    icache_bank even_bank (
        .clk(clk), .rst_i(rst_i), .lookup_addr_i(fip_even_o),
        .fill_en_i(fill_even), .fill_addr_i(mem_req_addr_o),
        .fill_beat_i(beat_idx), .fill_last_i(beat_last), .fill_word_i(mem_rsp_data_i),
        .hit_o(hit_even), .line_o(line_even_o)
    );

    icache_bank odd_bank (
        .clk(clk), .rst_i(rst_i), .lookup_addr_i(fip_odd_o),
        .fill_en_i(fill_odd), .fill_addr_i(mem_req_addr_o),
        .fill_beat_i(beat_idx), .fill_last_i(beat_last), .fill_word_i(mem_rsp_data_i),
        .hit_o(hit_odd), .line_o(line_odd_o)
    );

    refill_fsm refill_fsm_inst (
        .clk(clk), .rst_i(rst_i),
        .hit_even_i(hit_even), .hit_odd_i(hit_odd),
        .fip_even_i(fip_even_o), .fip_odd_i(fip_odd_o),
        .mem_req_ready_i(mem_req_ready_i), .mem_rsp_valid_i(mem_rsp_valid_i),
        .last_beat_i(beat_last),
        .mem_req_valid_o(mem_req_valid_o), .mem_req_addr_o(mem_req_addr_o),
        .mem_rsp_ready_o(mem_rsp_ready_o),
        .fill_even_o(fill_even), .fill_odd_o(fill_odd),
        .beat_o(rsp_beat), .beat_clear_o(beat_clear),
        .fetch_valid_o(fetch_valid_o)
    );

    beat_counter beat_counter_inst (
        .clk(clk), .rst_i(rst_i), .clear_i(beat_clear), .beat_i(rsp_beat),
        .beat_o(beat_idx), .last_o(beat_last)
    );

endmodule

// ==== src/fip_gen.sv ====
`timescale 1ns/1ps

module fip_gen (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               init_i,
    input  logic                               resteer_i,
    input  logic                               branch_i,
    input  logic [31:0]                        init_addr_i,
    input  logic [31:0]                        resteer_addr_i,
    input  logic [31:0]                        branch_addr_i,
    input  logic                               fetch_valid_i,
    input  logic                               fetch_ready_i,
    output logic [fetch_pkg::line_addr_w-1:0]  fip_even_o,
    output logic [fetch_pkg::line_addr_w-1:0]  fip_odd_o
);
    import fetch_pkg::*;

    redirect_src_e          redir_src;
    logic [31:0]            redir_addr;
    logic [line_addr_w-1:0] redir_line;
    logic [line_addr_w-1:0] redir_line_p1;
    logic [line_addr_w-1:0] fip_even_q;
    logic [line_addr_w-1:0] fip_odd_q;
    logic                   fetch_xfer;

    // init beats resteer beats branch
    always_comb begin
        if (init_i)
            redir_src = redir_init;
        else if (resteer_i)
            redir_src = redir_resteer;
        else if (branch_i)
            redir_src = redir_branch;
        else
            redir_src = redir_none;
    end

    always_comb begin
        case (redir_src)
            redir_init:    redir_addr = init_addr_i;
            redir_resteer: redir_addr = resteer_addr_i;
            default:       redir_addr = branch_addr_i;  // don't care when none
        endcase
    end

    // round up to the next line of each parity
    assign redir_line    = redir_addr[31:4];
    assign redir_line_p1 = redir_line + line_addr_w'(1);

    assign fetch_xfer = fetch_valid_i && fetch_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            fip_even_q <= '0;
            fip_odd_q  <= line_addr_w'(1);
        end else if (redir_src != redir_none) begin
            fip_even_q <= redir_line[0] ? redir_line_p1 : redir_line;
            fip_odd_q  <= redir_line[0] ? redir_line : redir_line_p1;
        end else if (fetch_xfer) begin
            fip_even_q <= fip_even_q + line_addr_w'(2);  // next line pair
            fip_odd_q  <= fip_odd_q + line_addr_w'(2);
        end
    end

    assign fip_even_o = fip_even_q;
    assign fip_odd_o  = fip_odd_q;

endmodule

// ==== src/icache_bank.sv ====
`timescale 1ns/1ps

module icache_bank (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic [fetch_pkg::line_addr_w-1:0]  lookup_addr_i,
    input  logic                               fill_en_i,
    input  logic [fetch_pkg::line_addr_w-1:0]  fill_addr_i,
    input  logic [fetch_pkg::beat_idx_w-1:0]   fill_beat_i,
    input  logic                               fill_last_i,
    input  logic [fetch_pkg::beat_w-1:0]       fill_word_i,
    output logic                               hit_o,
    output logic [fetch_pkg::line_w-1:0]       line_o
);
    import fetch_pkg::*;

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    logic [tag_w-1:0]                       tag_mem  [bank_lines];
    logic [beats_per_line-1:0][beat_w-1:0]  line_mem [bank_lines];
    logic [bank_lines-1:0]                  valid_q;

    logic [index_w-1:0] lookup_idx;
    logic [tag_w-1:0]   lookup_tag;
    logic [index_w-1:0] fill_idx;
    logic [tag_w-1:0]   fill_tag;

    // bit 0 is the bank parity and is not stored
    assign lookup_idx = lookup_addr_i[index_w:1];
    assign lookup_tag = lookup_addr_i[line_addr_w-1:index_w+1];
    assign fill_idx   = fill_addr_i[index_w:1];
    assign fill_tag   = fill_addr_i[line_addr_w-1:index_w+1];

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    assign hit_o  = valid_q[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
    assign line_o = line_mem[lookup_idx];  // word 0 in the low bits

    ////////////////////////////////////////////////////////////
    // fill
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            line_mem[fill_idx][fill_beat_i] <= fill_word_i;
            if (fill_last_i)
                tag_mem[fill_idx] <= fill_tag;
        end
    end

    // entry drops out on the first beat, comes back with the last one
    always_ff @(posedge clk) begin
        if (rst_i)
            valid_q <= '0;
        else if (fill_en_i)
            valid_q[fill_idx] <= fill_last_i;
    end

endmodule

// ==== src/refill_fsm.sv ====
`timescale 1ns/1ps

module refill_fsm (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               hit_even_i,
    input  logic                               hit_odd_i,
    input  logic [fetch_pkg::line_addr_w-1:0]  fip_even_i,
    input  logic [fetch_pkg::line_addr_w-1:0]  fip_odd_i,
    input  logic                               mem_req_ready_i,
    input  logic                               mem_rsp_valid_i,
    input  logic                               last_beat_i,
    output logic                               mem_req_valid_o,
    output logic [fetch_pkg::line_addr_w-1:0]  mem_req_addr_o,
    output logic                               mem_rsp_ready_o,
    output logic                               fill_even_o,
    output logic                               fill_odd_o,
    output logic                               beat_o,
    output logic                               beat_clear_o,
    output logic                               fetch_valid_o
);
    import fetch_pkg::*;

    refill_state_e          state_q;
    logic [line_addr_w-1:0] miss_addr_q;
    logic                   miss_odd_q;    // target bank of the refill
    logic                   any_miss;

    assign any_miss = !hit_even_i || !hit_odd_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: if (any_miss) state_q <= st_req;
                st_req:  if (mem_req_ready_i) state_q <= st_fill;
                st_fill: if (beat_o && last_beat_i) state_q <= st_idle;
                default: state_q <= st_idle;
            endcase
        end
    end

    // even bank is served first when both miss
    always_ff @(posedge clk) begin
        if (state_q == st_idle) begin
            miss_odd_q  <= hit_even_i;
            miss_addr_q <= hit_even_i ? fip_odd_i : fip_even_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // memory side and fill steering
    ////////////////////////////////////////////////////////////

    assign mem_req_valid_o = (state_q == st_req);
    assign mem_req_addr_o  = miss_addr_q;  // held until the fsm is idle again
    assign mem_rsp_ready_o = (state_q == st_fill);

    assign beat_o       = mem_rsp_valid_i && mem_rsp_ready_o;
    assign beat_clear_o = (state_q != st_fill);
    assign fill_even_o  = beat_o && !miss_odd_q;
    assign fill_odd_o   = beat_o && miss_odd_q;

    assign fetch_valid_o = (state_q == st_idle) && hit_even_i && hit_odd_i;

endmodule

// ==== testbench/fetch_checker.sv ====
`timescale 1ns/1ps

module fetch_checker (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               init_i,
    input  logic                               resteer_i,
    input  logic                               branch_i,
    input  logic [31:0]                        init_addr_i,
    input  logic [31:0]                        resteer_addr_i,
    input  logic [31:0]                        branch_addr_i,
    input  logic                               fetch_ready_i,
    input  logic                               fetch_valid_i,
    input  logic                               mem_req_valid_i,
    input  logic [fetch_pkg::line_w-1:0]       line_even_i,
    input  logic [fetch_pkg::line_w-1:0]       line_odd_i,
    input  logic [fetch_pkg::line_addr_w-1:0]  fip_even_i,
    input  logic [fetch_pkg::line_addr_w-1:0]  fip_odd_i,
    output int                                 xfer_count_o,
    output int                                 data_errs_o,
    output int                                 fip_errs_o,
    output int                                 reset_errs_o
);
    import fetch_pkg::*;

    logic [line_addr_w-1:0] exp_even;  // expected FIPs of the next transfer
    logic [line_addr_w-1:0] exp_odd;
    logic                   rst_q = 1'b0;

    initial begin
        xfer_count_o = 0;
        data_errs_o  = 0;
        fip_errs_o   = 0;
        reset_errs_o = 0;
    end

    // word k of line a as the memory model answers it
    function automatic logic [line_w-1:0] ref_line(input logic [line_addr_w-1:0] a);
        logic [line_w-1:0] line;
        for (int k = 0; k < beats_per_line; k++)
            line[k*beat_w +: beat_w] = (32'(a) * 32'h9e37_79b1) ^ (32'(k) * 32'h85eb_ca6b)
                                       ^ 32'h0f0f_1234;
        return line;
    endfunction

    ////////////////////////////////////////////////////////////
    // compare on every edge
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        redirect_src_e          src;
        logic [31:0]            addr;
        logic [line_addr_w-1:0] l;
        int                     bad_rst;
        int                     bad_fip;
        int                     bad_data;

        bad_rst  = 0;
        bad_fip  = 0;
        bad_data = 0;
        src  = init_i ? redir_init : resteer_i ? redir_resteer :
               branch_i ? redir_branch : redir_none;
        addr = (src == redir_init) ? init_addr_i :
               (src == redir_resteer) ? resteer_addr_i : branch_addr_i;
        l    = addr[31:4];
        rst_q <= rst_i;
        if (rst_q && fetch_valid_i) begin
            $display("FAIL fetch_valid_o expected %h got %h around reset", 1'b0, fetch_valid_i);
            bad_rst++;
        end
        if (rst_q && mem_req_valid_i) begin
            $display("FAIL mem_req_valid_o expected %h got %h around reset", 1'b0,
                     mem_req_valid_i);
            bad_rst++;
        end
        if (rst_i) begin
            exp_even <= '0;
            exp_odd  <= line_addr_w'(1);
        end else begin
            if (fetch_valid_i && fetch_ready_i) begin
                if (fip_even_i !== exp_even) begin
                    $display("FAIL fip_even_o expected %h got %h", exp_even, fip_even_i);
                    bad_fip++;
                end
                if (fip_odd_i !== exp_odd) begin
                    $display("FAIL fip_odd_o expected %h got %h", exp_odd, fip_odd_i);
                    bad_fip++;
                end
                if (line_even_i !== ref_line(exp_even)) begin
                    $display("FAIL line_even_o at %h expected %h got %h", exp_even,
                             ref_line(exp_even), line_even_i);
                    bad_data++;
                end
                if (line_odd_i !== ref_line(exp_odd)) begin
                    $display("FAIL line_odd_o at %h expected %h got %h", exp_odd,
                             ref_line(exp_odd), line_odd_i);
                    bad_data++;
                end
                xfer_count_o <= xfer_count_o + 1;
            end
            if (src != redir_none) begin
                exp_even <= (l + line_addr_w'(1)) & ~line_addr_w'(1);  // even line at or above
                exp_odd  <= l | line_addr_w'(1);
            end else if (fetch_valid_i && fetch_ready_i) begin
                exp_even <= exp_even + line_addr_w'(2);
                exp_odd  <= exp_odd + line_addr_w'(2);
            end
        end
        reset_errs_o <= reset_errs_o + bad_rst;
        fip_errs_o   <= fip_errs_o + bad_fip;
        data_errs_o  <= data_errs_o + bad_data;
    end

endmodule

// ==== testbench/fetch_props.sv ====
`timescale 1ns/1ps

module fetch_props (
    input  logic                               clk,
    input  logic                               rst_i,
    input  fetch_pkg::refill_state_e           state_i,
    input  logic                               mem_req_valid_i,
    input  logic [fetch_pkg::line_addr_w-1:0]  mem_req_addr_i,
    input  logic                               mem_req_ready_i,
    input  logic                               mem_rsp_ready_i,
    input  logic                               fetch_valid_i
);
    import fetch_pkg::*;

    int fail_count = 0;

    // request holds until memory takes it
    req_hold: assert property (@(posedge clk) disable iff (rst_i)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_addr_i))
        else begin
            $error("memory request dropped or changed before it was accepted");
            fail_count = fail_count + 1;
        end

    // fill opens only right after memory took the request
    rsp_ready_after_req: assert property (@(posedge clk) disable iff (rst_i)
        $rose(mem_rsp_ready_i) |-> $past(state_i) == st_req && $past(mem_req_ready_i))
        else begin
            $error("response ready raised without an accepted memory request");
            fail_count = fail_count + 1;
        end

    // covers later reset cycles and the first one after
    quiet_after_reset: assert property (@(posedge clk)
        $past(rst_i) |-> !fetch_valid_i && !mem_req_valid_i)
        else begin
            $error("fetch or memory request valid during or right after reset");
            fail_count = fail_count + 1;
        end

endmodule

bind refill_fsm fetch_props props_inst (
    .clk(clk),
    .rst_i(rst_i),
    .state_i(state_q),
    .mem_req_valid_i(mem_req_valid_o),
    .mem_req_addr_i(mem_req_addr_o),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_rsp_ready_i(mem_rsp_ready_o),
    .fetch_valid_i(fetch_valid_o)
);

// ==== testbench/tb_fetch_unit.sv ====
`timescale 1ns/1ps

module tb_fetch_unit;
    import fetch_pkg::*;

    localparam int num_xfers     = 600;
    localparam int max_gap       = 3;  // longest random stall of any handshake
    // miss detect, request wait and each beat may stall
    localparam int refill_cycles = 3 + (max_gap + 1) * (beats_per_line + 1);
    localparam int cycle_limit   = num_xfers * (2 * refill_cycles + max_gap + 1) * 2;

    logic                   clk = 1'b0;
    logic                   rst_i;
    logic                   init_i;
    logic                   resteer_i;
    logic                   branch_i;
    logic [31:0]            init_addr_i;
    logic [31:0]            resteer_addr_i;
    logic [31:0]            branch_addr_i;
    logic                   fetch_ready_i;
    logic                   mem_req_ready_i;
    logic                   mem_rsp_valid_i;
    logic [beat_w-1:0]      mem_rsp_data_i;
    logic                   fetch_valid_o;
    logic [line_w-1:0]      line_even_o;
    logic [line_w-1:0]      line_odd_o;
    logic [line_addr_w-1:0] fip_even_o;
    logic [line_addr_w-1:0] fip_odd_o;
    logic                   mem_req_valid_o;
    logic [line_addr_w-1:0] mem_req_addr_o;
    logic                   mem_rsp_ready_o;

    logic [31:0]            rng_q = 32'h06d6_0336;
    logic [line_addr_w-1:0] pending [$];  // accepted requests, oldest first
    int beat_k      = 0;
    int req_wait    = 0;
    int req_gap     = 0;
    int rsp_gap     = 0;
    int fetch_stall = 0;
    int neg_count   = 0;
    int cycles      = 0;
    int xfer_count;
    int data_errs;
    int fip_errs;
    int reset_errs;
    int total_errs;

    always #2 clk = ~clk;

    fetch_unit fetch_unit_inst (
        .clk(clk), .rst_i(rst_i),
        .init_i(init_i), .resteer_i(resteer_i), .branch_i(branch_i),
        .init_addr_i(init_addr_i), .resteer_addr_i(resteer_addr_i),
        .branch_addr_i(branch_addr_i), .fetch_ready_i(fetch_ready_i),
        .mem_req_ready_i(mem_req_ready_i), .mem_rsp_valid_i(mem_rsp_valid_i),
        .mem_rsp_data_i(mem_rsp_data_i), .fetch_valid_o(fetch_valid_o),
        .line_even_o(line_even_o), .line_odd_o(line_odd_o),
        .fip_even_o(fip_even_o), .fip_odd_o(fip_odd_o),
        .mem_req_valid_o(mem_req_valid_o), .mem_req_addr_o(mem_req_addr_o),
        .mem_rsp_ready_o(mem_rsp_ready_o)
    );

    fetch_checker fetch_checker_inst (
        .clk(clk), .rst_i(rst_i),
        .init_i(init_i), .resteer_i(resteer_i), .branch_i(branch_i),
        .init_addr_i(init_addr_i), .resteer_addr_i(resteer_addr_i),
        .branch_addr_i(branch_addr_i), .fetch_ready_i(fetch_ready_i),
        .fetch_valid_i(fetch_valid_o), .mem_req_valid_i(mem_req_valid_o),
        .line_even_i(line_even_o), .line_odd_i(line_odd_o),
        .fip_even_i(fip_even_o), .fip_odd_i(fip_odd_o),
        .xfer_count_o(xfer_count), .data_errs_o(data_errs),
        .fip_errs_o(fip_errs), .reset_errs_o(reset_errs)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] rand_next();
        rng_q = xorshift32(rng_q);
        return rng_q;
    endfunction

    // mostly a 64-line window so lines 32 apart collide, now and then a far one
    function automatic logic [31:0] pick_addr();
        logic [31:0] r;
        r = rand_next();
        if (r[31:28] == 4'h0)
            return {8'h3c, r[23:0]};
        return {22'h0, r[9:0]};
    endfunction

    function automatic logic [beat_w-1:0] mem_word(input logic [line_addr_w-1:0] a, input int k);
        return (32'(a) * 32'h9e37_79b1) ^ (32'(k) * 32'h85eb_ca6b) ^ 32'h0f0f_1234;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus and memory model
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        logic [31:0] r;
        logic        redirect;
        logic [2:0]  sel;

        r = rand_next();
        if (neg_count < 4)
            neg_count++;
        rst_i    = (neg_count < 4);  // four rising edges in reset
        redirect = !rst_i && (r[4:0] == 5'd0);
        sel      = r[7:5];
        init_i    = redirect && sel[2];
        resteer_i = redirect && sel[1];
        branch_i  = redirect && (sel[0] || sel == 3'b000);
        init_addr_i    = pick_addr();
        resteer_addr_i = pick_addr();
        branch_addr_i  = pick_addr();

        if (rst_i) begin
            fetch_ready_i = 1'b0;
        end else if (fetch_stall >= max_gap || r[10:9] != 2'b00) begin
            fetch_ready_i = 1'b1;
            fetch_stall   = 0;
        end else begin
            fetch_ready_i = 1'b0;
            fetch_stall++;
        end

        mem_req_ready_i = !rst_i && (req_wait >= req_gap);
        if (!rst_i && pending.size() > 0 && rsp_gap == 0) begin
            mem_rsp_valid_i = 1'b1;  // held until taken
            mem_rsp_data_i  = mem_word(pending[0], beat_k);
        end else begin
            mem_rsp_valid_i = 1'b0;
            mem_rsp_data_i  = '0;
            if (rsp_gap > 0)
                rsp_gap--;
        end
    end

    always @(posedge clk) begin
        if (rst_i) begin
            pending.delete();
            beat_k   = 0;
            req_wait = 0;
            req_gap  = 0;
            rsp_gap  = 0;
        end else begin
            if (mem_req_valid_o && mem_req_ready_i) begin
                pending.push_back(mem_req_addr_o);
                req_wait = 0;
                req_gap  = int'(rand_next() % (max_gap + 1));
            end else if (mem_req_valid_o) begin
                req_wait++;
            end
            if (mem_rsp_valid_i && mem_rsp_ready_o) begin
                rsp_gap = int'(rand_next() % (max_gap + 1));
                if (beat_k == beats_per_line - 1) begin
                    beat_k = 0;
                    void'(pending.pop_front());
                end else begin
                    beat_k++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_i)
            cycles <= cycles + 1;
    end

    initial begin
        rst_i           = 1'b1;
        init_i          = 1'b0;
        resteer_i       = 1'b0;
        branch_i        = 1'b0;
        init_addr_i     = '0;
        resteer_addr_i  = '0;
        branch_addr_i   = '0;
        fetch_ready_i   = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i  = '0;
        while (xfer_count < num_xfers && cycles < cycle_limit)
            @(posedge clk);
        @(negedge clk);
        total_errs = data_errs + fip_errs + reset_errs
                     + fetch_unit_inst.refill_fsm_inst.props_inst.fail_count;
        if (cycles >= cycle_limit)
            $display("run stopped at the cycle limit of %0d with %0d of %0d transfers done",
                     cycle_limit, xfer_count, num_xfers);
        $display("errors: data %0d, fip %0d, reset %0d, assertion %0d; transfers %0d",
                 data_errs, fip_errs, reset_errs,
                 fetch_unit_inst.refill_fsm_inst.props_inst.fail_count, xfer_count);
        if (total_errs == 0 && cycles < cycle_limit)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule
